// File: dbg_cfg.svh
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// Memory sizes
`define IM_BYTES      256
`define RB_REGS       8
`define DM_WORDS      16

// Host command bytes
`define CMD_LOAD      8'h4C
`define CMD_RUN       8'h43
`define CMD_STEP      8'h53

// Dump layout in bytes
`define DUMP_PC_BYTES 4
`define DUMP_RB_BYTES 32
`define DUMP_BYTES    100

`endif

// File: dbg_pkg.sv
package dbg_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  im_addr_t;
    typedef logic [2:0]  rb_addr_t;
    typedef logic [3:0]  dm_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_COUNT,
        LOAD_BYTES,
        RUN,
        STEP,
        DUMP_SEND,
        DUMP_WAIT
    } dbg_state_t;

    // MIPS opcode and funct subset
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2B;
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;

    localparam word_t HALT_WORD = '1;

endpackage

// File: instr_mem.sv
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module instr_mem (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_wr_en,
    input  dbg_pkg::im_addr_t  i_wr_addr,
    input  dbg_pkg::byte_t     i_wr_data,
    input  dbg_pkg::im_addr_t  i_rd_addr,
    output dbg_pkg::word_t     o_rd_data
);
    import dbg_pkg::*;

    byte_t mem [0:`IM_BYTES-1];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `IM_BYTES; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Little-endian word at the fetch address
    assign o_rd_data = {mem[i_rd_addr + 8'd3], mem[i_rd_addr + 8'd2],
                        mem[i_rd_addr + 8'd1], mem[i_rd_addr]};

    a_rd_aligned: assert property (@(posedge i_clock) disable iff (i_rst)
        i_rd_addr[1:0] == 2'b00);

endmodule

// File: reg_bank.sv
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module reg_bank (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_wr_en,
    input  dbg_pkg::rb_addr_t  i_wr_addr,
    input  dbg_pkg::word_t     i_wr_data,
    input  dbg_pkg::rb_addr_t  i_rs_addr,
    input  dbg_pkg::rb_addr_t  i_rt_addr,
    input  dbg_pkg::rb_addr_t  i_dbg_addr,
    output dbg_pkg::word_t     o_rs_data,
    output dbg_pkg::word_t     o_rt_data,
    output dbg_pkg::word_t     o_dbg_data
);
    import dbg_pkg::*;

    word_t regs [0:`RB_REGS-1];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `RB_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            // Register 0 stays zero
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs_data  = regs[i_rs_addr];
    assign o_rt_data  = regs[i_rt_addr];
    assign o_dbg_data = regs[i_dbg_addr];

    a_r0_zero: assert property (@(posedge i_clock) disable iff (i_rst)
        (i_rs_addr == '0) |-> (o_rs_data == '0));

endmodule

// File: data_mem.sv
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module data_mem (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_wr_en,
    input  dbg_pkg::dm_addr_t  i_addr,
    input  dbg_pkg::word_t     i_wr_data,
    input  dbg_pkg::dm_addr_t  i_dbg_addr,
    output dbg_pkg::word_t     o_rd_data,
    output dbg_pkg::word_t     o_dbg_data
);
    import dbg_pkg::*;

    word_t mem [0:`DM_WORDS-1];

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            for (int i = 0; i < `DM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            mem[i_addr] <= i_wr_data;
        end
    end

    assign o_rd_data  = mem[i_addr];
    assign o_dbg_data = mem[i_dbg_addr];

endmodule

// File: data_path.sv
`timescale 1ns/1ps

module data_path (
    input  logic               i_clock,
    input  logic               i_rst,
    input  logic               i_cpu_enable,
    input  logic               i_pc_clear,
    input  logic               i_im_wr_en,
    input  dbg_pkg::im_addr_t  i_im_addr,
    input  dbg_pkg::byte_t     i_im_data,
    input  dbg_pkg::rb_addr_t  i_rb_dbg_addr,
    input  dbg_pkg::dm_addr_t  i_dm_dbg_addr,
    output dbg_pkg::word_t     o_rb_data,
    output dbg_pkg::word_t     o_dm_data,
    output dbg_pkg::word_t     o_last_pc,
    output logic               o_hlt
);
    import dbg_pkg::*;

    word_t      pc;
    word_t      instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    rb_addr_t   rs;
    rb_addr_t   rt;
    rb_addr_t   rd;
    word_t      imm_ext;
    word_t      rs_data;
    word_t      rt_data;
    word_t      mem_rd_data;
    word_t      alu_b;
    word_t      alu_out;
    logic       is_add;
    logic       is_sub;
    logic       is_addi;
    logic       is_lw;
    logic       is_sw;
    logic       retire;
    logic       rb_we;
    logic       dm_we;
    rb_addr_t   rb_wr_addr;
    word_t      rb_wr_data;

    instr_mem instr_mem_inst (
        .i_clock   (i_clock),
        .i_rst     (i_rst),
        .i_wr_en   (i_im_wr_en),
        .i_wr_addr (i_im_addr),
        .i_wr_data (i_im_data),
        .i_rd_addr (pc[7:0]),
        .o_rd_data (instr)
    );

    // Only the low three bits of each register field are decoded
    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rs      = instr[23:21];
    assign rt      = instr[18:16];
    assign rd      = instr[13:11];
    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    assign is_add  = (opcode == OP_RTYPE) && (funct == FN_ADD);
    assign is_sub  = (opcode == OP_RTYPE) && (funct == FN_SUB);
    assign is_addi = (opcode == OP_ADDI);
    assign is_lw   = (opcode == OP_LW);
    assign is_sw   = (opcode == OP_SW);

    assign o_hlt   = (instr == HALT_WORD);
    assign retire  = i_cpu_enable && !o_hlt;

    reg_bank reg_bank_inst (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_wr_en    (rb_we),
        .i_wr_addr  (rb_wr_addr),
        .i_wr_data  (rb_wr_data),
        .i_rs_addr  (rs),
        .i_rt_addr  (rt),
        .i_dbg_addr (i_rb_dbg_addr),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .o_dbg_data (o_rb_data)
    );

    assign alu_b   = (is_add || is_sub) ? rt_data : imm_ext;
    assign alu_out = is_sub ? (rs_data - alu_b) : (rs_data + alu_b);

    data_mem data_mem_inst (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_wr_en    (dm_we),
        .i_addr     (alu_out[5:2]),
        .i_wr_data  (rt_data),
        .i_dbg_addr (i_dm_dbg_addr),
        .o_rd_data  (mem_rd_data),
        .o_dbg_data (o_dm_data)
    );

    assign dm_we      = retire && is_sw;
    assign rb_we      = retire && (is_add || is_sub || is_addi || is_lw);
    assign rb_wr_addr = (is_add || is_sub) ? rd : rt;
    assign rb_wr_data = is_lw ? mem_rd_data : alu_out;

    always_ff @(posedge i_clock) begin
        if (i_rst || i_pc_clear) begin
            pc <= '0;
        end else if (retire) begin
            pc <= pc + 32'd4;
        end
    end

    assign o_last_pc = pc;

    a_no_write_halted: assert property (@(posedge i_clock) disable iff (i_rst)
        o_hlt |-> !(reg_bank_inst.i_wr_en || data_mem_inst.i_wr_en));

endmodule

// File: debug_unit.sv
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module debug_unit (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  logic                 i_hlt,
    input  logic                 i_rx_done,
    input  dbg_pkg::byte_t       i_rx_data,
    input  logic                 i_tx_done,
    input  dbg_pkg::word_t       i_pc_value,
    input  dbg_pkg::word_t       i_rb_data,
    input  dbg_pkg::word_t       i_dm_data,
    output logic                 o_im_wr_en,
    output dbg_pkg::im_addr_t    o_im_addr,
    output dbg_pkg::byte_t       o_im_data,
    output logic                 o_cpu_enable,
    output logic                 o_pc_clear,
    output dbg_pkg::rb_addr_t    o_rb_addr,
    output dbg_pkg::dm_addr_t    o_dm_addr,
    output dbg_pkg::byte_t       o_tx_data,
    output logic                 o_tx_start,
    output dbg_pkg::dbg_state_t  o_state
);
    import dbg_pkg::*;

    dbg_state_t state;
    logic [9:0] load_cnt;
    logic [9:0] load_total;
    logic [6:0] dump_cnt;
    logic [6:0] rb_off;
    logic [6:0] dm_off;
    word_t      dump_word;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state      <= IDLE;
            load_cnt   <= '0;
            load_total <= '0;
            dump_cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    load_cnt <= '0;
                    dump_cnt <= '0;
                    if (i_rx_done) begin
                        case (i_rx_data)
                            `CMD_LOAD: state <= LOAD_COUNT;
                            `CMD_RUN:  state <= RUN;
                            `CMD_STEP: state <= STEP;
                            default:   state <= IDLE;
                        endcase
                    end
                end
                LOAD_COUNT: begin
                    if (i_rx_done) begin
                        // Four bytes per loaded word
                        load_total <= {i_rx_data, 2'b00};
                        state      <= (i_rx_data == '0) ? IDLE : LOAD_BYTES;
                    end
                end
                LOAD_BYTES: begin
                    if (i_rx_done) begin
                        load_cnt <= load_cnt + 10'd1;
                        if (load_cnt == load_total - 10'd1) begin
                            state <= IDLE;
                        end
                    end
                end
                RUN: begin
                    if (i_hlt) begin
                        state <= DUMP_SEND;
                    end
                end
                STEP: begin
                    state <= DUMP_SEND;
                end
                DUMP_SEND: begin
                    state <= DUMP_WAIT;
                end
                DUMP_WAIT: begin
                    if (i_tx_done) begin
                        if (dump_cnt == 7'(`DUMP_BYTES - 1)) begin
                            state <= IDLE;
                        end else begin
                            dump_cnt <= dump_cnt + 7'd1;
                            state    <= DUMP_SEND;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Loader writes each byte as it arrives
    assign o_im_wr_en = (state == LOAD_BYTES) && i_rx_done;
    assign o_im_addr  = load_cnt[7:0];
    assign o_im_data  = i_rx_data;
    assign o_pc_clear = (state == IDLE) && i_rx_done && (i_rx_data == `CMD_LOAD);

    assign o_cpu_enable = ((state == RUN) || (state == STEP)) && !i_hlt;

    // Dump order is PC, then registers, then data memory
    assign rb_off    = dump_cnt - 7'(`DUMP_PC_BYTES);
    assign dm_off    = dump_cnt - 7'(`DUMP_PC_BYTES + `DUMP_RB_BYTES);
    assign o_rb_addr = rb_off[4:2];
    assign o_dm_addr = dm_off[5:2];

    always_comb begin
        if (dump_cnt < 7'(`DUMP_PC_BYTES)) begin
            dump_word = i_pc_value;
        end else if (dump_cnt < 7'(`DUMP_PC_BYTES + `DUMP_RB_BYTES)) begin
            dump_word = i_rb_data;
        end else begin
            dump_word = i_dm_data;
        end
    end

    assign o_tx_data  = dump_word[{dump_cnt[1:0], 3'b000} +: 8];
    assign o_tx_start = (state == DUMP_SEND);
    assign o_state    = state;

    a_tx_pulse: assert property (@(posedge i_clock) disable iff (i_rst)
        o_tx_start |=> !o_tx_start);

    a_no_load_exec: assert property (@(posedge i_clock) disable iff (i_rst)
        !(o_cpu_enable && o_im_wr_en));

endmodule

// File: dbg_top.sv
`timescale 1ns/1ps

module dbg_top (
    input  logic                 i_clock,
    input  logic                 i_rst,
    input  logic                 i_rx_done,
    input  dbg_pkg::byte_t       i_rx_data,
    input  logic                 i_tx_done,
    output logic                 o_tx_start,
    output dbg_pkg::byte_t       o_tx_data,
    output logic                 o_hlt,
    output dbg_pkg::dbg_state_t  o_state
);
    import dbg_pkg::*;

    logic     im_wr_en;
    im_addr_t im_addr;
    byte_t    im_data;
    logic     cpu_enable;
    logic     pc_clear;
    rb_addr_t rb_addr;
    dm_addr_t dm_addr;
    word_t    rb_data;
    word_t    dm_data;
    word_t    pc;

    debug_unit debug_unit_inst (
        .i_clock      (i_clock),
        .i_rst        (i_rst),
        .i_hlt        (o_hlt),
        .i_rx_done    (i_rx_done),
        .i_rx_data    (i_rx_data),
        .i_tx_done    (i_tx_done),
        .i_pc_value   (pc),
        .i_rb_data    (rb_data),
        .i_dm_data    (dm_data),
        .o_im_wr_en   (im_wr_en),
        .o_im_addr    (im_addr),
        .o_im_data    (im_data),
        .o_cpu_enable (cpu_enable),
        .o_pc_clear   (pc_clear),
        .o_rb_addr    (rb_addr),
        .o_dm_addr    (dm_addr),
        .o_tx_data    (o_tx_data),
        .o_tx_start   (o_tx_start),
        .o_state      (o_state)
    );

    data_path data_path_inst (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_cpu_enable  (cpu_enable),
        .i_pc_clear    (pc_clear),
        .i_im_wr_en    (im_wr_en),
        .i_im_addr     (im_addr),
        .i_im_data     (im_data),
        .i_rb_dbg_addr (rb_addr),
        .i_dm_dbg_addr (dm_addr),
        .o_rb_data     (rb_data),
        .o_dm_data     (dm_data),
        .o_last_pc     (pc),
        .o_hlt         (o_hlt)
    );

endmodule

// File: tb_dbg_top.sv
`timescale 1ns/1ps
`include "dbg_cfg.svh"

module tb_dbg_top;
    import dbg_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic       i_clock;
    logic       i_rst;
    logic       i_rx_done;
    byte_t      i_rx_data;
    logic       i_tx_done;
    logic       o_tx_start;
    byte_t      o_tx_data;
    logic       o_hlt;
    dbg_state_t o_state;

    int    seed = 55412;
    word_t m_regs [0:`RB_REGS-1];
    word_t m_mem [0:`DM_WORDS-1];
    word_t m_imem [0:`IM_BYTES/4-1];
    word_t m_pc;
    byte_t dump [0:`DUMP_BYTES-1];
    byte_t prev_dump [0:`DUMP_BYTES-1];
    word_t prog [$];

    dbg_top dbg_top_inst (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_rx_done  (i_rx_done),
        .i_rx_data  (i_rx_data),
        .i_tx_done  (i_tx_done),
        .o_tx_start (o_tx_start),
        .o_tx_data  (o_tx_data),
        .o_hlt      (o_hlt),
        .o_state    (o_state)
    );

    initial begin
        i_clock = 1'b0;
        forever #20 i_clock = ~i_clock;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                                        name, expected, actual));
        end
    endtask

    function automatic word_t enc_r(input int rs, input int rt, input int rd,
                                    input logic [5:0] fn);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                    input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // Reference model of the processor state
    task automatic model_reset();
        for (int i = 0; i < `RB_REGS; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < `DM_WORDS; i++) begin
            m_mem[i] = '0;
        end
        for (int i = 0; i < `IM_BYTES / 4; i++) begin
            m_imem[i] = '0;
        end
        m_pc = '0;
    endtask

    task automatic write_reg(input int idx, input word_t value);
        if (idx != 0) begin
            m_regs[idx] = value;
        end
    endtask

    task automatic model_exec_one();
        word_t instr;
        word_t a;
        word_t b;
        word_t imm;
        word_t addr;
        int    rs;
        int    rt;
        int    rd;
        instr = m_imem[m_pc[7:2]];
        if (instr == HALT_WORD) begin
            return;
        end
        rs   = instr[25:21] % `RB_REGS;
        rt   = instr[20:16] % `RB_REGS;
        rd   = instr[15:11] % `RB_REGS;
        a    = m_regs[rs];
        b    = m_regs[rt];
        imm  = {{16{instr[15]}}, instr[15:0]};
        addr = ((a + imm) >> 2) % `DM_WORDS;
        case (instr[31:26])
            OP_RTYPE: begin
                if (instr[5:0] == FN_ADD) begin
                    write_reg(rd, a + b);
                end else if (instr[5:0] == FN_SUB) begin
                    write_reg(rd, a - b);
                end
            end
            OP_ADDI: write_reg(rt, a + imm);
            OP_LW:   write_reg(rt, m_mem[addr]);
            OP_SW:   m_mem[addr] = b;
            default: ;
        endcase
        m_pc = m_pc + 32'd4;
    endtask

    task automatic model_run();
        for (int n = 0; n < 1000; n++) begin
            if (m_imem[m_pc[7:2]] == HALT_WORD) begin
                break;
            end
            model_exec_one();
        end
    endtask

    // Dump order is PC, registers 0..7, memory 0..15, each LSB first
    function automatic byte_t expected_byte(input int idx);
        word_t w;
        if (idx < 4) begin
            w = m_pc;
        end else if (idx < 36) begin
            w = m_regs[(idx - 4) / 4];
        end else begin
            w = m_mem[(idx - 36) / 4];
        end
        return w[(idx % 4) * 8 +: 8];
    endfunction

    function automatic word_t dumped_word(input int base);
        return {dump[base + 3], dump[base + 2], dump[base + 1], dump[base]};
    endfunction

    task automatic reset_dut();
        i_rst = 1'b1;
        repeat (4) @(negedge i_clock);
        i_rst = 1'b0;
        model_reset();
    endtask

    task automatic send_byte(input byte_t b);
        i_rx_data = b;
        i_rx_done = 1'b1;
        @(negedge i_clock);
        i_rx_done = 1'b0;
    endtask

    task automatic wait_idle(input string name);
        int cnt;
        cnt = 0;
        while (o_state != IDLE) begin
            @(negedge i_clock);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                stop_with_failure($sformatf("%s: debug unit never returned to IDLE", name));
            end
        end
    endtask

    task automatic load_program();
        word_t w;
        send_byte(`CMD_LOAD);
        send_byte(8'(prog.size()));
        foreach (prog[i]) begin
            w = prog[i];
            for (int b = 0; b < 4; b++) begin
                send_byte(w[b * 8 +: 8]);
            end
            m_imem[i] = w;
        end
        m_pc = '0;
        wait_idle("load");
    endtask

    task automatic collect_dump(input string name, input bit inject);
        int cnt;
        int delay;
        for (int i = 0; i < `DUMP_BYTES; i++) begin
            cnt = 0;
            while (!o_tx_start) begin
                @(negedge i_clock);
                cnt++;
                if (cnt > WAIT_LIMIT) begin
                    stop_with_failure($sformatf("%s: no o_tx_start for dump byte %0d",
                                                name, i));
                end
            end
            dump[i] = o_tx_data;
            if (inject && i == `DUMP_BYTES / 2) begin
                // Stray host command mid-dump
                i_rx_data = `CMD_LOAD;
                i_rx_done = 1'b1;
            end
            delay = 1 + ($unsigned($random(seed)) % 6);
            for (int d = 0; d < delay; d++) begin
                @(negedge i_clock);
                i_rx_done = 1'b0;
                if (o_tx_start) begin
                    stop_with_failure($sformatf("%s: byte %0d started before i_tx_done",
                                                name, i + 1));
                end
            end
            i_tx_done = 1'b1;
            @(negedge i_clock);
            i_tx_done = 1'b0;
        end
        check({name, " state after dump"}, IDLE, o_state);
        for (int i = 0; i < `DUMP_BYTES; i++) begin
            check($sformatf("%s byte %0d", name, i), expected_byte(i), dump[i]);
        end
    endtask

    task automatic test_halt_only();
        reset_dut();
        prog = '{HALT_WORD};
        load_program();
        check("halt_only o_hlt after load", 1, o_hlt);
        send_byte(`CMD_RUN);
        model_run();
        collect_dump("halt_only", 1'b0);
        check("halt_only o_hlt", 1, o_hlt);
    endtask

    task automatic test_alu();
        reset_dut();
        prog = '{enc_i(OP_ADDI, 0, 1, 5), enc_i(OP_ADDI, 0, 2, -3),
                 enc_r(1, 2, 3, FN_ADD), enc_r(1, 2, 4, FN_SUB),
                 enc_i(OP_ADDI, 3, 5, 100), enc_r(0, 4, 6, FN_SUB), HALT_WORD};
        load_program();
        send_byte(`CMD_RUN);
        model_run();
        collect_dump("alu", 1'b0);
        check("alu pc", 4 * (prog.size() - 1), dumped_word(0));
    endtask

    task automatic test_mem();
        reset_dut();
        prog = '{enc_i(OP_ADDI, 0, 1, 'h1234), enc_i(OP_ADDI, 0, 2, -1),
                 enc_i(OP_SW, 0, 1, 8), enc_i(OP_SW, 0, 2, 60), enc_i(OP_SW, 0, 1, 64),
                 enc_i(OP_LW, 0, 3, 8), enc_i(OP_LW, 0, 4, 60), enc_i(OP_ADDI, 0, 0, 7),
                 enc_i(OP_LW, 0, 0, 8), enc_r(3, 0, 5, FN_ADD),
                 enc_i(OP_SW, 2, 5, -4), HALT_WORD};
        load_program();
        send_byte(`CMD_RUN);
        model_run();
        collect_dump("mem", 1'b0);
        check("mem register 0", 0, dumped_word(4));
    endtask

    task automatic test_step();
        reset_dut();
        prog = '{enc_i(OP_ADDI, 0, 1, 9), enc_i(OP_ADDI, 1, 2, 1),
                 enc_r(1, 2, 3, FN_SUB), HALT_WORD};
        load_program();
        for (int s = 0; s < 3; s++) begin
            send_byte(`CMD_STEP);
            model_exec_one();
            collect_dump($sformatf("step %0d", s), 1'b0);
            check($sformatf("step %0d pc", s), 32'(4 * (s + 1)), dumped_word(0));
        end
        prev_dump = dump;
        send_byte(`CMD_STEP);
        model_exec_one();
        collect_dump("step on halt", 1'b0);
        for (int i = 0; i < `DUMP_BYTES; i++) begin
            check($sformatf("step on halt byte %0d", i), prev_dump[i], dump[i]);
        end
    endtask

    task automatic test_random_tx();
        reset_dut();
        prog = '{enc_i(OP_ADDI, 0, 1, 'h7f), enc_i(OP_SW, 0, 1, 4),
                 enc_i(OP_ADDI, 1, 2, -200), enc_i(OP_SW, 0, 2, 12), HALT_WORD};
        load_program();
        send_byte(`CMD_RUN);
        model_run();
        collect_dump("random_tx", 1'b1);
        prev_dump = dump;
        // Second run on a halted machine repeats the same dump
        send_byte(`CMD_RUN);
        model_run();
        collect_dump("random_tx rerun", 1'b0);
        for (int i = 0; i < `DUMP_BYTES; i++) begin
            check($sformatf("random_tx rerun byte %0d", i), prev_dump[i], dump[i]);
        end
    endtask

    initial begin
        i_rst     = 1'b1;
        i_rx_done = 1'b0;
        i_rx_data = '0;
        i_tx_done = 1'b0;
        test_halt_only();
        test_alu();
        test_mem();
        test_step();
        test_random_tx();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+.
dbg_pkg.sv
instr_mem.sv
reg_bank.sv
data_mem.sv
data_path.sv
debug_unit.sv
dbg_top.sv
tb_dbg_top.sv

// File: Bender.yml
package:
  name: dbg_top

export_include_dirs:
  - .

sources:
  - dbg_pkg.sv
  - instr_mem.sv
  - reg_bank.sv
  - data_mem.sv
  - data_path.sv
  - debug_unit.sv
  - dbg_top.sv
  - target: test
    files:
      - tb_dbg_top.sv
